/* hdl/line_fifo.sv */
//----------------------------------------------------------------------------
// line FIFO
// single clock FIFO between packer and stream output, read word is
// registered one cycle after pop, with full, near-full and empty status
//----------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module line_fifo (
   input  wire logic                   i_aclk,
   input  wire logic                   i_aresetn,
   input  wire logic                   i_push,
   input  wire v2axis_pkg::que_word_t  i_wdata,
   input  wire logic                   i_pop,
   output v2axis_pkg::que_word_t       o_rdata,
   output logic                        o_full,
   output logic                        o_empty,
   output logic                        o_nfull
);

   localparam int CNT_W = v2axis_pkg::FIFO_AW + 1;

   v2axis_pkg::que_word_t               mem [v2axis_pkg::FIFO_DEP];

   logic [v2axis_pkg::FIFO_AW-1:0]      wr_ptr;
   logic [v2axis_pkg::FIFO_AW-1:0]      rd_ptr;
   logic [CNT_W-1:0]                    fill;        // words stored

   logic                                wr_en;
   logic                                rd_en;

   assign wr_en   = i_push & ~o_full;               // push while full dropped
   assign rd_en   = i_pop & ~o_empty;

   assign o_full  = (fill == CNT_W'(v2axis_pkg::FIFO_DEP));
   assign o_empty = (fill == '0);
   assign o_nfull = (fill >= CNT_W'(v2axis_pkg::NFULL_LVL));

   //-------------------------------------------------------------------------
   // pointers and fill level
   //-------------------------------------------------------------------------
   always_ff @(posedge i_aclk) begin
      if (!i_aresetn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         fill   <= '0;
      end else begin
         if (wr_en)
            wr_ptr <= wr_ptr + 1'b1;               // wraps at depth
         if (rd_en)
            rd_ptr <= rd_ptr + 1'b1;

         case ({wr_en, rd_en})
            2'b10:   fill <= fill + 1'b1;
            2'b01:   fill <= fill - 1'b1;
            default: fill <= fill;
         endcase
      end
   end

   //-------------------------------------------------------------------------
   // storage
   //-------------------------------------------------------------------------
   always_ff @(posedge i_aclk) begin
      if (wr_en)
         mem[wr_ptr] <= i_wdata;
      if (rd_en)
         o_rdata <= mem[rd_ptr];                  // valid the cycle after pop
   end

endmodule

`default_nettype wire

/* hdl/pixel_packer.sv */
//----------------------------------------------------------------------------
// pixel packer
// gates whole frames with the input enable, packs three 10-bit pixels
// per word (top bits left zero), flushes a partial word at line end and
// writes each word with its sof/sol/eol flags into the line FIFO
//----------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module pixel_packer (
   input  wire logic                   i_aclk,
   input  wire logic                   i_aresetn,
   input  wire v2axis_pkg::vid_in_t    i_vid,
   input  wire logic                   i_vin_en,
   input  wire logic                   i_full,
   output logic                        o_push,
   output v2axis_pkg::que_word_t       o_word
);

   logic                                frm_en;     // current frame accepted
   logic                                sof_pend;   // first word of frame not yet out
   logic                                sol_pend;   // word in progress holds hstr pixel
   logic [v2axis_pkg::PKC_DW-1:0]       pkt_cnt;    // next free slot
   logic [v2axis_pkg::QUE_DW-1:0]       px_acc;     // word under construction
   logic [v2axis_pkg::QUE_DW-1:0]       acc_nxt;

   logic                                pix_in;
   logic                                last_slot;
   logic                                word_done;

   assign pix_in    = i_vid.href & frm_en;
   assign last_slot = (pkt_cnt == v2axis_pkg::PKC_DW'(v2axis_pkg::PX_PER_WORD - 1));
   assign word_done = pix_in & (last_slot | i_vid.hend);

   //-------------------------------------------------------------------------
   // slot insert
   //-------------------------------------------------------------------------
   // slot 0 starts a fresh word, so unfilled slots of a flushed word are zero
   always_comb begin
      acc_nxt = (pkt_cnt == '0) ? '0 : px_acc;
      for (int k = 0; k < v2axis_pkg::PX_PER_WORD; k++) begin
         if (pkt_cnt == v2axis_pkg::PKC_DW'(k))
            acc_nxt[k*v2axis_pkg::PXDW +: v2axis_pkg::PXDW] = i_vid.pdat;
      end
   end

   //-------------------------------------------------------------------------
   // control
   //-------------------------------------------------------------------------
   always_ff @(posedge i_aclk) begin
      if (!i_aresetn) begin
         frm_en   <= 1'b0;
         sof_pend <= 1'b0;
         sol_pend <= 1'b0;
         pkt_cnt  <= '0;
         o_push   <= 1'b0;
      end else begin
         o_push <= word_done & ~i_full;           // word lost when FIFO full

         if (i_vid.fstr) begin
            frm_en   <= i_vin_en;                 // sampled once per frame
            sof_pend <= 1'b1;
            sol_pend <= 1'b0;
            pkt_cnt  <= '0;
         end else if (pix_in) begin
            if (word_done) begin
               pkt_cnt  <= '0;
               sol_pend <= 1'b0;
               sof_pend <= 1'b0;
            end else begin
               pkt_cnt  <= pkt_cnt + 1'b1;
               sol_pend <= sol_pend | i_vid.hstr;
            end
         end
      end
   end

   //-------------------------------------------------------------------------
   // payload
   //-------------------------------------------------------------------------
   always_ff @(posedge i_aclk) begin
      if (pix_in)
         px_acc <= acc_nxt;

      if (word_done) begin
         o_word.data <= acc_nxt;
         o_word.sof  <= sof_pend;
         o_word.sol  <= sol_pend | i_vid.hstr;
         o_word.eol  <= i_vid.hend;
      end
   end

endmodule

`default_nettype wire

/* hdl/stream_out.sv */
//----------------------------------------------------------------------------
// AXI4-Stream output stage
// pops the line FIFO, keeps up to two words in a hold queue while tready
// is low and drives tdata, tvalid, tlast and tuser from one output register
//----------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module stream_out (
   input  wire logic                     i_aclk,
   input  wire logic                     i_aresetn,
   input  wire logic                     i_empty,
   input  wire v2axis_pkg::que_word_t    i_rdata,
   output logic                          o_pop,
   input  wire logic                     i_tready,
   output logic [v2axis_pkg::AODW-1:0]   o_tdata,
   output logic                          o_tvalid,
   output logic                          o_tlast,
   output v2axis_pkg::axis_user_t        o_tuser
);

   localparam int QDEP = 2;                         // hold queue entries

   v2axis_pkg::que_word_t   out_q;                  // output register
   v2axis_pkg::que_word_t   hold_q [QDEP];          // hold queue, entry 0 is head
   logic [1:0]              q_cnt;
   logic                    rd_vld;                 // FIFO read word lands this cycle

   logic                    out_free;
   logic                    take_q;
   logic                    take_rd;
   logic                    push_q;
   logic [1:0]              wr_pos;
   logic [2:0]              occ;

   //-------------------------------------------------------------------------
   // flow control
   //-------------------------------------------------------------------------
   assign out_free = ~o_tvalid | i_tready;          // empty or transferring
   assign take_q   = out_free & (q_cnt != 2'd0);    // queue keeps ordering
   assign take_rd  = out_free & (q_cnt == 2'd0) & rd_vld;
   assign push_q   = rd_vld & ~take_rd;
   assign wr_pos   = q_cnt - {1'b0, take_q};

   // output reg + queue + word in flight, pop only while room for one more
   assign occ   = {2'b00, o_tvalid} + {1'b0, q_cnt} + {2'b00, rd_vld};
   assign o_pop = ~i_empty & (occ < 3'(QDEP + 1));

   always_ff @(posedge i_aclk) begin
      if (!i_aresetn) begin
         rd_vld <= 1'b0;
         q_cnt  <= 2'd0;
      end else begin
         rd_vld <= o_pop;
         q_cnt  <= q_cnt + {1'b0, push_q} - {1'b0, take_q};
      end
   end

   //-------------------------------------------------------------------------
   // hold queue
   //-------------------------------------------------------------------------
   always_ff @(posedge i_aclk) begin
      if (take_q)
         hold_q[0] <= hold_q[1];                  // shift toward head
      if (push_q)
         hold_q[wr_pos[0]] <= i_rdata;            // after shift, wins on entry 0
   end

   //-------------------------------------------------------------------------
   // output register
   //-------------------------------------------------------------------------
   always_ff @(posedge i_aclk) begin
      if (!i_aresetn) begin
         o_tvalid <= 1'b0;
         out_q    <= '0;
      end else begin
         if (take_q) begin
            out_q    <= hold_q[0];
            o_tvalid <= 1'b1;
         end else if (take_rd) begin
            out_q    <= i_rdata;                  // bypass when queue empty
            o_tvalid <= 1'b1;
         end else if (out_free) begin
            o_tvalid <= 1'b0;
         end
      end
   end

   // pixels zero-extended, top bits always zero in PAD mode
   assign o_tdata     = {{(v2axis_pkg::AODW - v2axis_pkg::QUE_DW){1'b0}}, out_q.data};
   assign o_tuser.sof = out_q.sof;
   assign o_tuser.sol = out_q.sol;
   assign o_tuser.eol = out_q.eol;
   assign o_tlast     = out_q.eol;                // packet = one line

endmodule

`default_nettype wire

/* hdl/v2axi4s_top.sv */
//----------------------------------------------------------------------------
// video to AXI4-Stream master, top level
// packer -> line FIFO -> stream output, all on aclk
//----------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module v2axi4s_top (
   input  wire logic                          aclk,
   input  wire logic                          aresetn,
   input  wire logic                          i_fstr,
   input  wire logic                          i_hstr,
   input  wire logic                          i_hend,
   input  wire logic                          i_href,
   input  wire logic                          i_vin_en,
   input  wire logic [v2axis_pkg::PXDW-1:0]   i_pdat,
   output logic      [v2axis_pkg::AODW-1:0]   o_tdata,
   output logic                               o_tvalid,
   output logic                               o_tlast,
   output logic      [2:0]                    o_tuser,   // {sof, sol, eol}
   input  wire logic                          i_tready,
   output logic                               o_fifo_nfull,
   output logic                               o_fifo_empty
);

   v2axis_pkg::vid_in_t     vid;
   v2axis_pkg::que_word_t   wr_word;
   v2axis_pkg::que_word_t   rd_word;
   logic                    push;
   logic                    pop;
   logic                    fifo_full;

   assign vid = '{fstr: i_fstr, hstr: i_hstr, hend: i_hend, href: i_href, pdat: i_pdat};

   pixel_packer u_packer (
      .i_aclk    (aclk),
      .i_aresetn (aresetn),
      .i_vid     (vid),
      .i_vin_en  (i_vin_en),
      .i_full    (fifo_full),
      .o_push    (push),
      .o_word    (wr_word)
   );

   line_fifo u_fifo (
      .i_aclk    (aclk),
      .i_aresetn (aresetn),
      .i_push    (push),
      .i_wdata   (wr_word),
      .i_pop     (pop),
      .o_rdata   (rd_word),
      .o_full    (fifo_full),
      .o_empty   (o_fifo_empty),
      .o_nfull   (o_fifo_nfull)
   );

   stream_out u_stream (
      .i_aclk    (aclk),
      .i_aresetn (aresetn),
      .i_empty   (o_fifo_empty),
      .i_rdata   (rd_word),
      .o_pop     (pop),
      .i_tready  (i_tready),
      .o_tdata   (o_tdata),
      .o_tvalid  (o_tvalid),
      .o_tlast   (o_tlast),
      .o_tuser   (o_tuser)
   );

endmodule

`default_nettype wire

/* hdl/v2axis_pkg.sv */
//----------------------------------------------------------------------------
// video to AXI4-Stream shared definitions
// widths, FIFO sizing and the word formats passed between the packer,
// the line FIFO and the stream output stage
//----------------------------------------------------------------------------
`default_nettype none

package v2axis_pkg;

   //-------------------------------------------------------------------------
   // widths and sizes
   //-------------------------------------------------------------------------
   localparam int PXDW        = 10;                // pixel width
   localparam int PX_PER_WORD = 3;                 // PAD mode, 3 pixels per word
   localparam int QUE_DW      = PXDW * PX_PER_WORD;
   localparam int AODW        = 32;                // tdata width
   localparam int FIFO_DEP    = 16;
   localparam int FIFO_AW     = 4;
   localparam int NFULL_LVL   = 14;                // near-full threshold
   localparam int PKC_DW      = 2;                 // slot counter width

   //-------------------------------------------------------------------------
   // bundles
   //-------------------------------------------------------------------------
   // native video input, one pixel per clock
   typedef struct packed {
      logic            fstr;
      logic            hstr;
      logic            hend;
      logic            href;
      logic [PXDW-1:0] pdat;
   } vid_in_t;

   // one queued word, framing flags travel with the pixels
   typedef struct packed {
      logic              sof;
      logic              sol;
      logic              eol;
      logic [QUE_DW-1:0] data;
   } que_word_t;

   // tuser side band
   typedef struct packed {
      logic sof;
      logic sol;
      logic eol;
   } axis_user_t;

endpackage

`default_nettype wire

/* sim.f */
hdl/v2axis_pkg.sv
hdl/pixel_packer.sv
hdl/line_fifo.sv
hdl/stream_out.sv
hdl/v2axi4s_top.sv
tb/tb_v2axi4s.sv

/* tb/tb_v2axi4s.sv */
//----------------------------------------------------------------------------
// testbench for the video to AXI4-Stream master
// drives random frames and lines, models the packed words with their
// framing flags and checks the stream output with assertions
//----------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_v2axi4s;

   localparam int WAIT_LIMIT = 500;                 // cycles per wait loop

   typedef struct packed {
      v2axis_pkg::axis_user_t          user;
      logic [v2axis_pkg::AODW-1:0]     data;
   } exp_word_t;

   logic                              aclk;
   logic                              aresetn;
   logic                              i_fstr;
   logic                              i_hstr;
   logic                              i_hend;
   logic                              i_href;
   logic                              i_vin_en;
   logic [v2axis_pkg::PXDW-1:0]       i_pdat;
   logic                              i_tready;
   logic [v2axis_pkg::AODW-1:0]       o_tdata;
   logic                              o_tvalid;
   logic                              o_tlast;
   logic [2:0]                        o_tuser;
   logic                              o_fifo_nfull;
   logic                              o_fifo_empty;

   exp_word_t   exp_q [$];
   exp_word_t   exp_head;                           // copy of queue head
   int          exp_cnt;
   int          err_cnt;
   logic        bp_mode;                            // random tready when set
   logic        frm_sof;                            // next word opens a frame
   logic [31:0] rnd_t;

   v2axi4s_top uut (
      .aclk (aclk), .aresetn (aresetn),
      .i_fstr (i_fstr), .i_hstr (i_hstr), .i_hend (i_hend), .i_href (i_href),
      .i_vin_en (i_vin_en), .i_pdat (i_pdat),
      .o_tdata (o_tdata), .o_tvalid (o_tvalid), .o_tlast (o_tlast), .o_tuser (o_tuser),
      .i_tready (i_tready), .o_fifo_nfull (o_fifo_nfull), .o_fifo_empty (o_fifo_empty)
   );

   initial aclk = 1'b0;
   always #5 aclk = ~aclk;

   always @(posedge aclk) begin
      #1;
      rnd_t    = $urandom;
      i_tready = bp_mode ? rnd_t[0] : 1'b1;
   end

   //-------------------------------------------------------------------------
   // checks
   //-------------------------------------------------------------------------
   a_reset: assert property (@(posedge aclk) !aresetn |=>
      (!o_tvalid && !o_tlast && o_tuser == 3'b000 && o_fifo_empty && !o_fifo_nfull))
      else begin
         err_cnt++;
         $display("ERR reset o_tvalid=%h o_tlast=%h o_tuser=%h o_fifo_empty=%h o_fifo_nfull=%h",
                  $sampled(o_tvalid), $sampled(o_tlast), $sampled(o_tuser),
                  $sampled(o_fifo_empty), $sampled(o_fifo_nfull));
      end

   a_extra: assert property (@(posedge aclk) disable iff (!aresetn)
      (o_tvalid && i_tready) |-> exp_cnt != 0)
      else begin
         err_cnt++;
         $display("transfer seen while no word was expected, o_tdata=%h", $sampled(o_tdata));
      end

   a_data: assert property (@(posedge aclk) disable iff (!aresetn)
      (o_tvalid && i_tready && exp_cnt != 0) |-> o_tdata == exp_head.data)
      else begin
         err_cnt++;
         $display("ERR o_tdata got %h exp %h", $sampled(o_tdata), $sampled(exp_head.data));
      end

   a_user: assert property (@(posedge aclk) disable iff (!aresetn)
      (o_tvalid && i_tready && exp_cnt != 0) |-> o_tuser == exp_head.user)
      else begin
         err_cnt++;
         $display("ERR o_tuser got %h exp %h", $sampled(o_tuser), $sampled(exp_head.user));
      end

   a_last: assert property (@(posedge aclk) disable iff (!aresetn)
      (o_tvalid && i_tready && exp_cnt != 0) |-> o_tlast == exp_head.user.eol)
      else begin
         err_cnt++;
         $display("ERR o_tlast got %h exp %h", $sampled(o_tlast), $sampled(exp_head.user.eol));
      end

   a_hold: assert property (@(posedge aclk) disable iff (!aresetn)
      (o_tvalid && !i_tready) |=>
      (o_tvalid && $stable(o_tdata) && $stable(o_tuser) && $stable(o_tlast)))
      else begin
         err_cnt++;
         $display("ERR held word changed o_tdata %h->%h o_tuser %h->%h o_tvalid=%h",
                  $past(o_tdata), $sampled(o_tdata), $past(o_tuser), $sampled(o_tuser),
                  $sampled(o_tvalid));
      end

   //-------------------------------------------------------------------------
   // scoreboard helpers
   //-------------------------------------------------------------------------
   task automatic refresh_head();
      exp_cnt  = exp_q.size();
      exp_head = (exp_cnt != 0) ? exp_q[0] : '0;
   endtask

   always @(posedge aclk) begin
      if (aresetn && o_tvalid && i_tready && exp_q.size() > 0) begin
         void'(exp_q.pop_front());
         refresh_head();
      end
   end

   task automatic timeout_fail(input string what);
      $display("timeout while waiting for %s", what);
      $display("errors: %0d", err_cnt);
      $display("Some tests failed");
      $finish;
   endtask

   task automatic wait_fifo_empty();
      int n;
      n = 0;
      while (!o_fifo_empty && n < WAIT_LIMIT) begin
         @(posedge aclk);
         #1;
         n++;
      end
      if (!o_fifo_empty)
         timeout_fail("the FIFO to drain");
   endtask

   task automatic wait_drained();
      int n;
      n = 0;
      while ((exp_cnt != 0 || o_tvalid) && n < WAIT_LIMIT) begin
         @(posedge aclk);
         #1;
         n++;
      end
      if (exp_cnt != 0 || o_tvalid)
         timeout_fail("the expected words to be transferred");
   endtask

   //-------------------------------------------------------------------------
   // stimulus
   //-------------------------------------------------------------------------
   // one line of len pixels and its expected words
   task automatic drive_line(input int len, input logic en);
      logic [v2axis_pkg::QUE_DW-1:0] acc;
      logic [31:0]                   rnd;
      exp_word_t                     w;
      int                            slot;
      logic                          first_word;
      acc        = '0;
      slot       = 0;
      first_word = 1'b1;
      for (int i = 0; i < len; i++) begin
         rnd    = $urandom;
         i_href = 1'b1;
         i_hstr = (i == 0);
         i_hend = (i == len - 1);
         i_pdat = rnd[v2axis_pkg::PXDW-1:0];
         acc[slot*v2axis_pkg::PXDW +: v2axis_pkg::PXDW] = i_pdat;
         if (slot == v2axis_pkg::PX_PER_WORD - 1 || i == len - 1) begin
            if (en) begin
               w.user.sof = frm_sof;
               w.user.sol = first_word;
               w.user.eol = (i == len - 1);
               w.data     = {{(v2axis_pkg::AODW - v2axis_pkg::QUE_DW){1'b0}}, acc};
               exp_q.push_back(w);
               refresh_head();
               frm_sof = 1'b0;
            end
            acc        = '0;                     // flushed slots stay zero
            slot       = 0;
            first_word = 1'b0;
         end else begin
            slot++;
         end
         @(posedge aclk);
         #1;
      end
      i_href = 1'b0;
      i_hstr = 1'b0;
      i_hend = 1'b0;
      repeat (2) begin
         @(posedge aclk);
         #1;
      end
      wait_fifo_empty();                         // last word has left the FIFO
   endtask

   // line lengths count up from fixed_len or are random when it is 0
   task automatic run_frame(input logic en, input int nlines, input int fixed_len);
      int len;
      i_vin_en = en;
      i_fstr   = 1'b1;
      frm_sof  = en;
      @(posedge aclk);
      #1;
      i_fstr   = 1'b0;
      i_vin_en = ~en;                            // ignored until next fstr
      for (int l = 0; l < nlines; l++) begin
         len = (fixed_len != 0) ? fixed_len + l : 1 + int'($urandom % 30);
         drive_line(len, en);
      end
      wait_drained();
   endtask

   initial begin
      void'($urandom(32'h29f21496));
      err_cnt  = 0;
      bp_mode  = 1'b0;
      frm_sof  = 1'b0;
      aresetn  = 1'b0;
      i_fstr   = 1'b0;
      i_hstr   = 1'b0;
      i_hend   = 1'b0;
      i_href   = 1'b0;
      i_vin_en = 1'b0;
      i_pdat   = '0;
      i_tready = 1'b1;
      refresh_head();
      repeat (4) @(posedge aclk);
      #1 aresetn = 1'b1;
      repeat (2) @(posedge aclk);
      #1;

      run_frame(1'b1, 6, 1);                     // lengths 1 to 6
      run_frame(1'b1, 4, 0);
      bp_mode = 1'b1;
      run_frame(1'b1, 5, 0);
      run_frame(1'b0, 3, 0);                     // gated frame
      run_frame(1'b1, 5, 0);
      run_frame(1'b1, 3, 28);

      a_final: assert (exp_q.size() == 0)
         else begin
            err_cnt++;
            $display("expected queue still holds %0d words at the end", exp_q.size());
         end
      $display("errors: %0d", err_cnt);
      if (err_cnt == 0)
         $display("All tests passed");
      else
         $display("Some tests failed");
      $finish;
   end

endmodule

`default_nettype wire
